// File: glb_pkg.sv
// Global buffer shared definitions
`default_nettype none

package glb_pkg;

    // ==================================================================
    // Default sizes
    // ==================================================================
    localparam int NUM_BANK_DEF  = 4;
    // Rows per bank, power of two
    localparam int SRAM_WORD_DEF = 8;
    localparam int MAXPAR        = 2;
    localparam int LANE_W        = 16;
    localparam int ADDR_W        = 8;

    typedef logic [LANE_W-1:0] lane_t;
    // Lane 0 sits in the low bits
    typedef logic [MAXPAR*LANE_W-1:0] wide_t;
    typedef logic [$clog2(MAXPAR+1)-1:0] par_t;

    typedef struct packed {
        logic              lap;
        logic [ADDR_W-1:0] idx;
    } ptr_t;

    typedef enum logic {
        PORT_UNCONFIGURED,
        PORT_ACTIVE
    } port_state_e;

    // ==================================================================
    // Ring pointer helpers
    // ==================================================================
    // Step by one word, wrap at capacity minus one
    function automatic ptr_t ptr_next(ptr_t p, logic [ADDR_W-1:0] cap);
        ptr_t n;
        if (p.idx == cap - 1'b1) begin
            n.idx = '0;
            n.lap = ~p.lap;
        end else begin
            n.idx = p.idx + 1'b1;
            n.lap = p.lap;
        end
        return n;
    endfunction

    // Words between tail and head
    function automatic logic [ADDR_W-1:0] ptr_used(ptr_t head, ptr_t tail,
                                                   logic [ADDR_W-1:0] cap);
        logic [ADDR_W-1:0] diff;
        diff = head.idx - tail.idx;
        if (head.lap != tail.lap) begin
            diff = diff + cap;
        end
        return diff;
    endfunction

    // ==================================================================
    // Bank mapping
    // ==================================================================
    // First bank of the group holding word idx
    function automatic int bank_base(int first, int par, int idx, int row_w,
                                     int num_bank);
        return (first + (idx >> row_w) * par) % num_bank;
    endfunction

    // Distance of a bank past the group base, with wrap
    function automatic int bank_dist(int bank, int base, int num_bank);
        return (bank + num_bank - base) % num_bank;
    endfunction

    function automatic logic in_group(int bank, int base, int par, int num_bank);
        return bank_dist(bank, base, num_bank) < par;
    endfunction

endpackage

`default_nettype wire

// File: glb_if.sv
// Global buffer internal interfaces
`default_nettype none
`timescale 1ns/10ps

// Port configuration, held after the handshake
interface glb_cfg_if #(
    parameter int NUM_BANK = glb_pkg::NUM_BANK_DEF
);
    logic [$clog2(NUM_BANK)-1:0] first_bank;
    glb_pkg::par_t               par_bank;
    logic [glb_pkg::ADDR_W-1:0]  capacity;
    logic                        active;

    modport drv (output first_bank, output par_bank, output capacity, output active);
    modport rcv (input first_bank, input par_bank, input capacity, input active);
endinterface

// Bank write request, no back-pressure
interface glb_bank_wr_if #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
);
    logic [NUM_BANK-1:0]          bank_mask;
    logic [$clog2(NUM_BANK)-1:0]  base_bank;
    logic [$clog2(SRAM_WORD)-1:0] row;
    glb_pkg::wide_t               data;

    modport drv (output bank_mask, output base_bank, output row, output data);
    modport rcv (input bank_mask, input base_bank, input row, input data);
endinterface

// Bank read request, rdata one cycle later and held
interface glb_bank_rd_if #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
);
    logic [NUM_BANK-1:0]          bank_mask;
    logic [$clog2(NUM_BANK)-1:0]  base_bank;
    logic [$clog2(SRAM_WORD)-1:0] row;
    glb_pkg::wide_t               rdata;

    modport drv (output bank_mask, output base_bank, output row, input rdata);
    modport rcv (input bank_mask, input base_bank, input row, output rdata);
endinterface

`default_nettype wire

// File: glb_cfg_regs.sv
// Global buffer configuration registers
`default_nettype none
`timescale 1ns/10ps

module glb_cfg_regs #(
    parameter int NUM_BANK = glb_pkg::NUM_BANK_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_vld_i,
    input  logic [$clog2(NUM_BANK)-1:0] cfg_first_bank_i,
    input  glb_pkg::par_t              cfg_par_bank_i,
    input  logic [glb_pkg::ADDR_W-1:0] cfg_capacity_i,
    output logic                       cfg_rdy_o,
    glb_cfg_if.drv                     cfg
);

    glb_pkg::port_state_e        state_q;
    glb_pkg::port_state_e        state_d;
    logic [$clog2(NUM_BANK)-1:0] first_bank_q;
    glb_pkg::par_t               par_bank_q;
    logic [glb_pkg::ADDR_W-1:0]  capacity_q;
    logic                        cfg_acc;

    assign cfg_rdy_o = (state_q == glb_pkg::PORT_UNCONFIGURED);
    assign cfg_acc   = cfg_vld_i && cfg_rdy_o;

    // One-way FSM, only reset returns to unconfigured
    always_comb begin
        state_d = state_q;
        case (state_q)
            glb_pkg::PORT_UNCONFIGURED: begin
                if (cfg_vld_i) begin
                    state_d = glb_pkg::PORT_ACTIVE;
                end
            end
            default: state_d = glb_pkg::PORT_ACTIVE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= glb_pkg::PORT_UNCONFIGURED;
            first_bank_q <= '0;
            par_bank_q   <= '0;
            capacity_q   <= '0;
        end else begin
            state_q <= state_d;
            if (cfg_acc) begin
                first_bank_q <= cfg_first_bank_i;
                par_bank_q   <= cfg_par_bank_i;
                capacity_q   <= cfg_capacity_i;
            end
        end
    end

    assign cfg.first_bank = first_bank_q;
    assign cfg.par_bank   = par_bank_q;
    assign cfg.capacity   = capacity_q;
    assign cfg.active     = (state_q == glb_pkg::PORT_ACTIVE);

endmodule

`default_nettype wire

// File: glb_wr_port.sv
// Global buffer write port
`default_nettype none
`timescale 1ns/10ps

module glb_wr_port #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    glb_cfg_if.rcv                     cfg,
    input  glb_pkg::wide_t             wr_dat_i,
    input  logic                       wr_vld_i,
    output logic                       wr_rdy_o,
    output logic [glb_pkg::ADDR_W-1:0] wr_free_o,
    input  glb_pkg::ptr_t              rd_ptr_i,
    output glb_pkg::ptr_t              wr_ptr_o,
    glb_bank_wr_if.drv                 bank
);

    localparam int BANK_W = $clog2(NUM_BANK);
    localparam int ROW_W  = $clog2(SRAM_WORD);

    glb_pkg::ptr_t              wr_ptr_q;
    logic                       full;
    logic                       wr_acc;
    logic [glb_pkg::ADDR_W-1:0] used;
    logic [BANK_W-1:0]          base;
    logic [NUM_BANK-1:0]        mask;

    // ==================================================================
    // Flow control
    // ==================================================================
    // rd_ptr_i counts delivered words, so a word held at the output still
    // occupies its slot
    assign full     = (wr_ptr_q.idx == rd_ptr_i.idx) && (wr_ptr_q.lap != rd_ptr_i.lap);
    assign wr_rdy_o = cfg.active && !full;
    assign wr_acc   = wr_vld_i && wr_rdy_o;

    assign used      = glb_pkg::ptr_used(wr_ptr_q, rd_ptr_i, cfg.capacity);
    assign wr_free_o = cfg.active ? cfg.capacity - used : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (wr_acc) begin
            wr_ptr_q <= glb_pkg::ptr_next(wr_ptr_q, cfg.capacity);
        end
    end

    assign wr_ptr_o = wr_ptr_q;

    // ==================================================================
    // Bank request
    // ==================================================================
    assign base = BANK_W'(glb_pkg::bank_base(int'(cfg.first_bank), int'(cfg.par_bank),
                                             int'(wr_ptr_q.idx), ROW_W, NUM_BANK));

    // par_bank banks from the group base
    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            mask[b] = wr_acc && glb_pkg::in_group(b, int'(base), int'(cfg.par_bank),
                                                  NUM_BANK);
        end
    end

    assign bank.bank_mask = mask;
    assign bank.base_bank = base;
    assign bank.row       = wr_ptr_q.idx[ROW_W-1:0];
    assign bank.data      = wr_dat_i;

endmodule

`default_nettype wire

// File: glb_rd_port.sv
// Global buffer read port
`default_nettype none
`timescale 1ns/10ps

module glb_rd_port #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    glb_cfg_if.rcv                     cfg,
    input  glb_pkg::ptr_t              wr_ptr_i,
    output glb_pkg::ptr_t              rd_ptr_o,
    output logic                       rd_vld_o,
    output logic [glb_pkg::ADDR_W-1:0] rd_avail_o,
    input  logic                       rd_rdy_i,
    glb_bank_rd_if.drv                 bank
);

    localparam int BANK_W = $clog2(NUM_BANK);
    localparam int ROW_W  = $clog2(SRAM_WORD);

    // Issue pointer runs ahead of the release pointer by rd_vld_q
    glb_pkg::ptr_t       iss_ptr_q;
    glb_pkg::ptr_t       rel_ptr_q;
    logic                rd_vld_q;
    logic                empty;
    logic                issue;
    logic                deliver;
    logic [BANK_W-1:0]   base;
    logic [NUM_BANK-1:0] mask;

    // ==================================================================
    // Issue and output stage
    // ==================================================================
    assign empty   = (iss_ptr_q == wr_ptr_i);
    assign issue   = cfg.active && !empty && (!rd_vld_q || rd_rdy_i);
    assign deliver = rd_vld_q && rd_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_ptr_q <= '0;
            rel_ptr_q <= '0;
            rd_vld_q  <= 1'b0;
        end else begin
            if (issue) begin
                iss_ptr_q <= glb_pkg::ptr_next(iss_ptr_q, cfg.capacity);
            end
            if (deliver) begin
                rel_ptr_q <= glb_pkg::ptr_next(rel_ptr_q, cfg.capacity);
            end
            // Valid follows the issue, drops once taken
            if (issue) begin
                rd_vld_q <= 1'b1;
            end else if (rd_rdy_i) begin
                rd_vld_q <= 1'b0;
            end
        end
    end

    assign rd_vld_o   = rd_vld_q;
    assign rd_ptr_o   = rel_ptr_q;
    assign rd_avail_o = cfg.active ? glb_pkg::ptr_used(wr_ptr_i, iss_ptr_q, cfg.capacity)
                                   : '0;

    // ==================================================================
    // Bank request
    // ==================================================================
    assign base = BANK_W'(glb_pkg::bank_base(int'(cfg.first_bank), int'(cfg.par_bank),
                                             int'(iss_ptr_q.idx), ROW_W, NUM_BANK));

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            mask[b] = issue && glb_pkg::in_group(b, int'(base), int'(cfg.par_bank),
                                                 NUM_BANK);
        end
    end

    assign bank.bank_mask = mask;
    assign bank.base_bank = base;
    assign bank.row       = iss_ptr_q.idx[ROW_W-1:0];

endmodule

`default_nettype wire

// File: glb_sram_bank.sv
// Global buffer SRAM bank
`default_nettype none
`timescale 1ns/10ps

module glb_sram_bank #(
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [$clog2(SRAM_WORD)-1:0] waddr_i,
    input  glb_pkg::lane_t               wdata_i,
    input  logic                         re_i,
    input  logic [$clog2(SRAM_WORD)-1:0] raddr_i,
    output glb_pkg::lane_t               rdata_o
);

    glb_pkg::lane_t mem [SRAM_WORD];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: glb_bank_array.sv
// Global buffer bank array
`default_nettype none
`timescale 1ns/10ps

module glb_bank_array #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    glb_bank_wr_if.rcv wr,
    glb_bank_rd_if.rcv rd
);

    localparam int BANK_W = $clog2(NUM_BANK);
    localparam int SEL_W  = (glb_pkg::MAXPAR > 1) ? $clog2(glb_pkg::MAXPAR) : 1;

    glb_pkg::lane_t    bank_rdata [NUM_BANK];
    logic [BANK_W-1:0] rd_base_q;
    glb_pkg::wide_t    rdata;

    // ==================================================================
    // Banks with write lane routing
    // ==================================================================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        logic [SEL_W-1:0] lane_sel;

        // Lane number is the distance from the group base
        assign lane_sel = SEL_W'(glb_pkg::bank_dist(b, int'(wr.base_bank), NUM_BANK)
                                 % glb_pkg::MAXPAR);

        glb_sram_bank #(
            .SRAM_WORD (SRAM_WORD)
        ) u_bank (
            .clk     (clk),
            .we_i    (wr.bank_mask[b]),
            .waddr_i (wr.row),
            .wdata_i (wr.data[lane_sel*glb_pkg::LANE_W +: glb_pkg::LANE_W]),
            .re_i    (rd.bank_mask[b]),
            .raddr_i (rd.row),
            .rdata_o (bank_rdata[b])
        );
    end

    // ==================================================================
    // Read lane gathering
    // ==================================================================
    // Base of the last issued read, matches the held bank data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_base_q <= '0;
        end else if (|rd.bank_mask) begin
            rd_base_q <= rd.base_bank;
        end
    end

    always_comb begin
        for (int i = 0; i < glb_pkg::MAXPAR; i++) begin
            rdata[i*glb_pkg::LANE_W +: glb_pkg::LANE_W] =
                bank_rdata[(int'(rd_base_q) + i) % NUM_BANK];
        end
    end

    assign rd.rdata = rdata;

endmodule

`default_nettype wire

// File: glb_top.sv
// Global buffer slice top level
`default_nettype none
`timescale 1ns/10ps

module glb_top #(
    parameter int NUM_BANK  = glb_pkg::NUM_BANK_DEF,
    parameter int SRAM_WORD = glb_pkg::SRAM_WORD_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Configuration
    input  logic                        cfg_vld_i,
    output logic                        cfg_rdy_o,
    input  logic [$clog2(NUM_BANK)-1:0] cfg_first_bank_i,
    input  glb_pkg::par_t               cfg_par_bank_i,
    input  logic [glb_pkg::ADDR_W-1:0]  cfg_capacity_i,
    // Write stream
    input  glb_pkg::wide_t              wr_dat_i,
    input  logic                        wr_vld_i,
    output logic                        wr_rdy_o,
    output logic [glb_pkg::ADDR_W-1:0]  wr_free_o,
    // Read stream
    output glb_pkg::wide_t              rd_dat_o,
    output logic                        rd_vld_o,
    input  logic                        rd_rdy_i,
    output logic [glb_pkg::ADDR_W-1:0]  rd_avail_o
);

    glb_pkg::ptr_t wr_ptr;
    glb_pkg::ptr_t rd_ptr;

    glb_cfg_if #(.NUM_BANK(NUM_BANK)) cfg_if ();
    glb_bank_wr_if #(.NUM_BANK(NUM_BANK), .SRAM_WORD(SRAM_WORD)) bank_wr ();
    glb_bank_rd_if #(.NUM_BANK(NUM_BANK), .SRAM_WORD(SRAM_WORD)) bank_rd ();

    glb_cfg_regs #(
        .NUM_BANK (NUM_BANK)
    ) u_cfg_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg_vld_i        (cfg_vld_i),
        .cfg_first_bank_i (cfg_first_bank_i),
        .cfg_par_bank_i   (cfg_par_bank_i),
        .cfg_capacity_i   (cfg_capacity_i),
        .cfg_rdy_o        (cfg_rdy_o),
        .cfg              (cfg_if.drv)
    );

    glb_wr_port #(
        .NUM_BANK  (NUM_BANK),
        .SRAM_WORD (SRAM_WORD)
    ) u_wr_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg_if.rcv),
        .wr_dat_i  (wr_dat_i),
        .wr_vld_i  (wr_vld_i),
        .wr_rdy_o  (wr_rdy_o),
        .wr_free_o (wr_free_o),
        .rd_ptr_i  (rd_ptr),
        .wr_ptr_o  (wr_ptr),
        .bank      (bank_wr.drv)
    );

    glb_rd_port #(
        .NUM_BANK  (NUM_BANK),
        .SRAM_WORD (SRAM_WORD)
    ) u_rd_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg_if.rcv),
        .wr_ptr_i   (wr_ptr),
        .rd_ptr_o   (rd_ptr),
        .rd_vld_o   (rd_vld_o),
        .rd_avail_o (rd_avail_o),
        .rd_rdy_i   (rd_rdy_i),
        .bank       (bank_rd.drv)
    );

    glb_bank_array #(
        .NUM_BANK  (NUM_BANK),
        .SRAM_WORD (SRAM_WORD)
    ) u_bank_array (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (bank_wr.rcv),
        .rd    (bank_rd.rcv)
    );

    // Banks hold the read data until the next issue
    assign rd_dat_o = bank_rd.rdata;

endmodule

`default_nettype wire

// File: glb_assertions.sv
// Global buffer handshake assertions
`default_nettype none
`timescale 1ns/10ps

module glb_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       cfg_rdy_o,
    input glb_pkg::wide_t             wr_dat_i,
    input logic                       wr_vld_i,
    input logic                       wr_rdy_o,
    input glb_pkg::wide_t             rd_dat_o,
    input logic                       rd_vld_o,
    input logic                       rd_rdy_i,
    input logic [glb_pkg::ADDR_W-1:0] rd_avail_o
);

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld_i && !wr_rdy_o |=> wr_vld_i && $stable(wr_dat_i))
        else $error("write request dropped or changed before ready");

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_vld_o && !rd_rdy_i |=> rd_vld_o && $stable(rd_dat_o))
        else $error("read data changed under back-pressure");

    // Issue seen from the ports: active, words waiting and the output slot free
    a_rd_issue: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_rdy_o && (rd_avail_o != '0) && (!rd_vld_o || rd_rdy_i) |=> rd_vld_o)
        else $error("read valid did not follow issue");

    a_cfg_first: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_rdy_o && cfg_rdy_o))
        else $error("write ready while unconfigured");

endmodule

bind glb_top glb_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_rdy_o  (cfg_rdy_o),
    .wr_dat_i   (wr_dat_i),
    .wr_vld_i   (wr_vld_i),
    .wr_rdy_o   (wr_rdy_o),
    .rd_dat_o   (rd_dat_o),
    .rd_vld_o   (rd_vld_o),
    .rd_rdy_i   (rd_rdy_i),
    .rd_avail_o (rd_avail_o)
);

`default_nettype wire

// File: glb_tb_checker.sv
// Global buffer testbench checker
`default_nettype none
`timescale 1ns/10ps

module glb_tb_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  int                         test_id_i,
    input  glb_pkg::par_t              par_i,
    input  logic [glb_pkg::ADDR_W-1:0] cap_i,
    input  logic                       cfg_rdy_i,
    input  logic                       wr_rdy_i,
    input  logic                       rd_vld_i,
    input  logic                       rd_rdy_i,
    input  glb_pkg::wide_t             rd_dat_i,
    input  logic [glb_pkg::ADDR_W-1:0] wr_free_i,
    input  logic [glb_pkg::ADDR_W-1:0] rd_avail_i,
    input  glb_pkg::wide_t             exp_word_i,
    input  logic                       stat_chk_i,
    input  logic [2+2*glb_pkg::ADDR_W:0] exp_stat_i,
    output int                         deliv_cnt_o,
    output int                         err_cnt_o,
    output int                         chk_cnt_o
);

    logic [2+2*glb_pkg::ADDR_W:0] act_stat;
    glb_pkg::wide_t               lanes;
    int                           new_chk;
    int                           new_err;

    function automatic string test_name(int id);
        case (id)
            0: return "reset_state";
            1: return "config_once";
            2: return "stream_order";
            3: return "fill_full";
            default: return "single_lane_offset";
        endcase
    endfunction

    // Only lanes below the parallel count carry data
    always_comb begin
        lanes = '0;
        for (int i = 0; i < glb_pkg::MAXPAR; i++) begin
            if (i < int'(par_i)) begin
                lanes[i*glb_pkg::LANE_W +: glb_pkg::LANE_W] = '1;
            end
        end
    end

    assign act_stat = {cfg_rdy_i, wr_rdy_i, rd_vld_i, wr_free_i, rd_avail_i};

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deliv_cnt_o <= 0;
        end else begin
            new_chk = 0;
            new_err = 0;
            if (rd_vld_i && rd_rdy_i) begin
                deliv_cnt_o <= deliv_cnt_o + 1;
                new_chk = new_chk + 1;
                if ((rd_dat_i & lanes) !== (exp_word_i & lanes)) begin
                    $display("mismatch test=%s word=%0d expected=%h actual=%h",
                             test_name(test_id_i), deliv_cnt_o, exp_word_i & lanes,
                             rd_dat_i & lanes);
                    new_err = new_err + 1;
                end
            end
            // Status snapshot of cfg_rdy, wr_rdy, rd_vld, free and avail
            if (stat_chk_i) begin
                new_chk = new_chk + 1;
                if (act_stat !== exp_stat_i) begin
                    $display("mismatch test=%s status expected=%h actual=%h",
                             test_name(test_id_i), exp_stat_i, act_stat);
                    new_err = new_err + 1;
                end
            end
            if (!cfg_rdy_i && (int'(wr_free_i) + int'(rd_avail_i) > int'(cap_i))) begin
                $display("test %s: free %0d plus available %0d is more than capacity %0d",
                         test_name(test_id_i), wr_free_i, rd_avail_i, cap_i);
                new_err = new_err + 1;
            end
            chk_cnt_o <= chk_cnt_o + new_chk;
            err_cnt_o <= err_cnt_o + new_err;
        end
    end

endmodule

`default_nettype wire

// File: glb_tb.sv
// Global buffer testbench
`default_nettype none
`timescale 1ns/10ps

module glb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 10
) (
    input  logic rst_req_i,
    output logic clk,
    output logic rst_n
);
    int cnt = RST_CYCLES;

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        if (rst_req_i) begin
            cnt <= RST_CYCLES;
        end else if (cnt > 0) begin
            cnt <= cnt - 1;
        end
    end

    assign rst_n = (cnt == 0);
endmodule

module glb_tb;

    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT   = NUM_TESTS * 400;
    localparam int AW        = glb_pkg::ADDR_W;

    logic clk, rst_n, rst_req;
    logic cfg_vld, cfg_rdy, wr_vld, wr_rdy, rd_vld, rd_rdy;
    logic [1:0] cfg_first;
    glb_pkg::par_t cfg_par;
    logic [AW-1:0] cfg_cap, wr_free, rd_avail, cur_cap;
    glb_pkg::wide_t wr_dat, rd_dat, exp_word;
    glb_pkg::par_t cur_par;
    logic stat_chk;
    logic [2+2*AW:0] exp_stat;
    int test_id, deliv_cnt, err_cnt, chk_cnt, err_before;
    int cyc_cnt = 0;
    logic [31:0] rnd;

    glb_clk_gen u_clk (.rst_req_i(rst_req), .clk(clk), .rst_n(rst_n));

    glb_top #(.NUM_BANK(4), .SRAM_WORD(8)) uut (
        .clk(clk), .rst_n(rst_n),
        .cfg_vld_i(cfg_vld), .cfg_rdy_o(cfg_rdy), .cfg_first_bank_i(cfg_first),
        .cfg_par_bank_i(cfg_par), .cfg_capacity_i(cfg_cap),
        .wr_dat_i(wr_dat), .wr_vld_i(wr_vld), .wr_rdy_o(wr_rdy), .wr_free_o(wr_free),
        .rd_dat_o(rd_dat), .rd_vld_o(rd_vld), .rd_rdy_i(rd_rdy), .rd_avail_o(rd_avail)
    );

    glb_tb_checker u_chk (
        .clk(clk), .rst_n(rst_n), .test_id_i(test_id), .par_i(cur_par), .cap_i(cur_cap),
        .cfg_rdy_i(cfg_rdy), .wr_rdy_i(wr_rdy), .rd_vld_i(rd_vld), .rd_rdy_i(rd_rdy),
        .rd_dat_i(rd_dat), .wr_free_i(wr_free), .rd_avail_i(rd_avail),
        .exp_word_i(exp_word), .stat_chk_i(stat_chk), .exp_stat_i(exp_stat),
        .deliv_cnt_o(deliv_cnt), .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected data of the nth word from its own xorshift sequence
    function automatic glb_pkg::wide_t ref_word(input int n);
        logic [31:0] s;
        s = 32'h777 ^ 32'h5a5a_0000;
        for (int i = 0; i <= n; i++) begin
            s = xorshift(s);
        end
        return s;
    endfunction

    always_comb exp_word = ref_word(deliv_cnt);

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles in test %0d", cyc_cnt, test_id);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic apply_reset();
        rst_req <= 1'b1;
        cfg_vld <= 1'b0;
        wr_vld  <= 1'b0;
        rd_rdy  <= 1'b0;
        @(posedge clk);
        rst_req <= 1'b0;
        @(posedge clk);
        wait (rst_n);
        @(posedge clk);
    endtask

    // Checks the cycle that follows the call
    task automatic expect_status(input logic c, input logic w, input logic r,
                                 input logic [AW-1:0] free, input logic [AW-1:0] avail);
        stat_chk <= 1'b1;
        exp_stat <= {c, w, r, free, avail};
        @(posedge clk);
        stat_chk <= 1'b0;
    endtask

    task automatic configure(input logic [1:0] first, input glb_pkg::par_t par,
                             input logic [AW-1:0] cap);
        cfg_vld   <= 1'b1;
        cfg_first <= first;
        cfg_par   <= par;
        cfg_cap   <= cap;
        @(posedge clk);
        cfg_vld   <= 1'b0;
    endtask

    // Writes n words with optional random valid and ready
    task automatic stream(input int n, input bit rand_vld, input bit rand_rdy);
        int  sent;
        logic acc;
        sent = 0;
        while (sent < n || deliv_cnt < n) begin
            @(posedge clk);
            rnd = xorshift(rnd);
            acc = wr_vld && wr_rdy;
            if (acc) begin
                sent++;
            end
            if (!wr_vld || acc) begin
                if (sent < n && (!rand_vld || rnd[3])) begin
                    wr_vld <= 1'b1;
                    wr_dat <= ref_word(sent);
                end else begin
                    wr_vld <= 1'b0;
                end
            end
            rd_rdy <= rand_rdy ? rnd[8] : 1'b1;
        end
    endtask

    // Error count settles one edge after the last check
    task automatic end_test(input string name);
        @(posedge clk);
        $display("test %s done with %0d errors", name, err_cnt - err_before);
        err_before = err_cnt;
    endtask

    initial begin
        rst_req    = 1'b0;
        cfg_vld    = 1'b0;
        cfg_first  = '0;
        cfg_par    = '0;
        cfg_cap    = '0;
        wr_dat     = '0;
        wr_vld     = 1'b0;
        rd_rdy     = 1'b0;
        stat_chk   = 1'b0;
        exp_stat   = '0;
        cur_par    = 2'd2;
        cur_cap    = 8'd12;
        test_id    = 0;
        err_before = 0;
        rnd        = 32'h777;
        wait (rst_n);
        @(posedge clk);
        expect_status(1'b1, 1'b0, 1'b0, 8'd0, 8'd0);
        end_test("reset_state");

        test_id <= 1;
        configure(2'd0, 2'd2, 8'd12);
        expect_status(1'b0, 1'b1, 1'b0, 8'd12, 8'd0);
        configure(2'd0, 2'd1, 8'd5);
        expect_status(1'b0, 1'b1, 1'b0, 8'd12, 8'd0);
        end_test("config_once");

        test_id <= 2;
        stream(40, 1'b1, 1'b1);
        end_test("stream_order");

        // ==============================================================
        // Fill to full with the reader stalled and drain
        // ==============================================================
        test_id <= 3;
        apply_reset();
        configure(2'd0, 2'd2, 8'd12);
        rd_rdy <= 1'b0;
        for (int i = 0; i < 12; i++) begin
            wr_vld <= 1'b1;
            wr_dat <= ref_word(i);
            @(posedge clk);
            while (!wr_rdy) begin
                @(posedge clk);
            end
        end
        wr_vld <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < 6; i++) begin
            expect_status(1'b0, 1'b0, 1'b1, 8'd0, 8'd11);
        end
        rd_rdy <= 1'b1;
        wait (deliv_cnt == 12);
        @(posedge clk);
        expect_status(1'b0, 1'b1, 1'b0, 8'd12, 8'd0);
        end_test("fill_full");

        test_id <= 4;
        apply_reset();
        cur_par <= 2'd1;
        cur_cap <= 8'd16;
        configure(2'd1, 2'd1, 8'd16);
        stream(30, 1'b1, 1'b1);
        end_test("single_lane_offset");

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: glb.f
glb_pkg.sv
glb_if.sv
glb_cfg_regs.sv
glb_wr_port.sv
glb_rd_port.sv
glb_sram_bank.sv
glb_bank_array.sv
glb_top.sv
glb_assertions.sv
glb_tb_checker.sv
glb_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f glb.f --top-module glb_tb -o glb_sim

out=$(./obj_dir/glb_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
